//--- Makefile
VERILATOR ?= verilator
TOP       := tb_row_arbiter
FILELIST  := compile.f
VFLAGS    := --binary --timing --assert -Wno-fatal
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Verification passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and search $(LOG) for the pass message"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "Pass message not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- compile.f
+incdir+verilog
verilog/row_arbiter_pkg.sv
verilog/sync_fifo.sv
verilog/slot_tracker.sv
verilog/slot_memory.sv
verilog/prio_scheduler.sv
verilog/engine_dispatch.sv
verilog/row_arbiter.sv
testbench/row_arbiter_assertions.sv
testbench/tb_row_arbiter.sv

//--- testbench/row_arbiter_assertions.sv
`timescale 1ns/1ns
`include "row_arbiter_macros.svh"

// Port-level protocol checks, bound into row_arbiter
module row_arbiter_assertions import row_arbiter_pkg::*; (
  input logic                   clk,
  input logic                   rst,
  input logic                   rowarb_rdy,
  input pkt_meta_t [1:0]        rowarb_pkt,
  input logic [1:0]             rowarb_pkt_valid,
  input logic [1:0]             bke_rdy,
  input logic                   bkarb_pkt_ignore,
  input cmd_t                   bkarb_cmd,
  input logic [`DATA_WIDTH-1:0] rowarb_data
);
  int error_count = 0;  // Failed assertions, read by the testbench

  // First clock out of reset sees empty outputs and room for packets
  a_reset_state: assert property (@(posedge clk)
    $fell(rst) |-> (rowarb_pkt_valid == 2'b00) && rowarb_rdy)
    else begin $error("Outputs not idle after reset"); error_count++; end

  // AiM engine only gets priority 1
  a_route_aim: assert property (@(posedge clk) disable iff (rst)
    rowarb_pkt_valid[1] |-> (rowarb_pkt[1].prio == 2'd1))
    else begin $error("Non priority 1 packet on AiM output"); error_count++; end

  // Bank engine gets priority 0 and 2
  a_route_bank: assert property (@(posedge clk) disable iff (rst)
    rowarb_pkt_valid[0] |-> (rowarb_pkt[0].prio == 2'd0 || rowarb_pkt[0].prio == 2'd2))
    else begin $error("Wrong priority on bank engine output"); error_count++; end

  for (genvar i = 0; i < 2; i++) begin : g_hold
    // Stalled head stays put
    a_hold: assert property (@(posedge clk) disable iff (rst)
      rowarb_pkt_valid[i] && !bke_rdy[i] |=> rowarb_pkt_valid[i] && $stable(rowarb_pkt[i]))
      else begin $error("Engine output changed while stalled"); error_count++; end
  end

  // Ignored or non-consuming command leaves payload output alone
  a_no_release: assert property (@(posedge clk) disable iff (rst)
    bkarb_pkt_ignore || (bkarb_cmd < CMD_MRS) |=> $stable(rowarb_data))
    else begin $error("Payload output changed without a release"); error_count++; end

endmodule

//--- testbench/tb_row_arbiter.sv
`timescale 1ns/1ns
`include "row_arbiter_macros.svh"

module tb_row_arbiter import row_arbiter_pkg::*; ();
  localparam int TRAFFIC_CYC = 600;
  localparam int STIM_CYC    = 4 + 60 + TRAFFIC_CYC + 300;  // Reset plus fill, traffic and drain
  localparam int CYC_LIMIT   = 2 * STIM_CYC;

  logic                       clk = 1'b0;
  logic                       rst;
  pkt_t                       ui_pkt;
  logic                       ui_pkt_valid;
  logic                       rowarb_rdy;
  pkt_meta_t [1:0]            rowarb_pkt;
  logic [1:0]                 rowarb_pkt_valid;
  logic [1:0]                 bke_rdy;
  logic                       bkarb_pkt_valid;
  logic                       bkarb_pkt_ignore;
  cmd_t                       bkarb_cmd;
  logic [`SLOT_PTR_WIDTH-1:0] bkarb_data_ptr;
  logic [`DATA_WIDTH-1:0]     rowarb_data;
  logic [`MASK_WIDTH-1:0]     rowarb_mask;

  // Scoreboard indexed by marker
  logic [`DATA_WIDTH-1:0]     exp_data [256];
  logic [`MASK_WIDTH-1:0]     exp_mask [256];
  pkt_t                       sent_pkt [256];               // Whole packet as sent
  bit                         emerged [256];
  logic [7:0]                 slot_marker [`ROWARB_DEPTH];  // Marker held by each slot
  logic [`SLOT_PTR_WIDTH-1:0] rel_q [$];                    // Emerged and not yet released

  int         sent;
  int         accepted;
  int         emerged_cnt;
  int         released;
  int         errors;
  int         fails;
  int         cycles = 0;
  int         pkt_quota;   // Markers allowed so far
  int         pkt_pct;
  int         rdy_pct;
  int         rel_pct;
  bit         real_only;   // Only slot-consuming commands
  bit         took;        // Packet accepted at last edge
  bit         chk_pending;
  logic [7:0] chk_marker;

  always #4 clk = ~clk;

  row_arbiter u_dut (.*);

  bind row_arbiter row_arbiter_assertions u_assert (.*);

  always @(posedge clk) begin
    cycles++;
    if (cycles > CYC_LIMIT) begin
      $display("Timeout: run went past %0d cycles without finishing", CYC_LIMIT);
      $display("Verification failed");
      $finish;
    end
  end

  task automatic new_packet();
    ui_pkt.marker      = 8'(sent);  // Unique per packet
    ui_pkt.bcast       = 1'($urandom_range(1));
    ui_pkt.prio        = `PRIO_WIDTH'($urandom_range(2));
    ui_pkt.bk_addr     = `BK_ADDR_WIDTH'($urandom);
    ui_pkt.row_addr    = `ROW_ADDR_WIDTH'($urandom);
    ui_pkt.col_addr    = `COL_ADDR_WIDTH'($urandom);
    ui_pkt.req_type    = req_t'($urandom_range(2));
    ui_pkt.mask        = `MASK_WIDTH'($urandom);
    ui_pkt.data        = {$urandom, $urandom};
    exp_data[8'(sent)] = ui_pkt.data;
    exp_mask[8'(sent)] = ui_pkt.mask;
    sent_pkt[8'(sent)] = ui_pkt;
    ui_pkt_valid       = 1'b1;
    sent++;
  endtask

  // Release, ignored command or non-consuming command on the oldest emerged slot
  task automatic drive_bank_cmd();
    int kind;
    bkarb_pkt_valid  = 1'b0;
    bkarb_pkt_ignore = 1'b0;
    if (rel_q.size() == 0 || $urandom_range(99) >= rel_pct) return;
    kind            = real_only ? 0 : int'($urandom_range(2));
    bkarb_pkt_valid = 1'b1;
    bkarb_data_ptr  = rel_q[0];
    case (kind)
      0: begin
        bkarb_cmd = cmd_t'($urandom_range(6, 4));  // MRS, WR or RD
        void'(rel_q.pop_front());
      end
      1: begin
        bkarb_pkt_ignore = 1'b1;
        bkarb_cmd        = cmd_t'($urandom_range(6));
      end
      default: bkarb_cmd = cmd_t'($urandom_range(3));  // NOP to REF
    endcase
  endtask

  // Metadata header above data_ptr matches the packet header above mask and data
  task automatic check_header(input int idx);
    pkt_meta_t got;
    pkt_t      want;
    got  = rowarb_pkt[idx];
    want = sent_pkt[got.marker];
    assert (got[$bits(pkt_meta_t)-1:`SLOT_PTR_WIDTH] ==
            want[$bits(pkt_t)-1:`MASK_WIDTH+`DATA_WIDTH]) else begin
      $display("[FAIL] %0t rowarb_pkt[%0d] header got %h expected %h", $time, idx,
               got[$bits(pkt_meta_t)-1:`SLOT_PTR_WIDTH],
               want[$bits(pkt_t)-1:`MASK_WIDTH+`DATA_WIDTH]);
      errors++;
    end
  endtask

  // One falling edge that checks, drives and predicts the next rising edge
  task automatic run_cycle();
    logic exp_rdy;
    @(negedge clk);
    if (chk_pending) begin
      assert (rowarb_data == exp_data[chk_marker]) else begin
        $display("[FAIL] %0t rowarb_data got %h expected %h",
                 $time, rowarb_data, exp_data[chk_marker]);
        errors++;
      end
      assert (rowarb_mask == exp_mask[chk_marker]) else begin
        $display("[FAIL] %0t rowarb_mask got %h expected %h",
                 $time, rowarb_mask, exp_mask[chk_marker]);
        errors++;
      end
      chk_pending = 1'b0;
    end
    exp_rdy = (accepted - released) < `ROWARB_DEPTH;  // Free slot left
    assert (rowarb_rdy == exp_rdy) else begin
      $display("[FAIL] %0t rowarb_rdy got %b expected %b", $time, rowarb_rdy, exp_rdy);
      errors++;
    end
    if (took) ui_pkt_valid = 1'b0;
    if (!ui_pkt_valid && sent < pkt_quota && $urandom_range(99) < pkt_pct) new_packet();
    for (int i = 0; i < 2; i++) bke_rdy[i] = ($urandom_range(99) < rdy_pct);
    drive_bank_cmd();
    took = ui_pkt_valid && rowarb_rdy;
    if (took) accepted++;
    for (int i = 0; i < 2; i++) begin
      if (rowarb_pkt_valid[i] && bke_rdy[i]) begin  // Leaves at next edge
        check_header(i);
        slot_marker[rowarb_pkt[i].data_ptr] = rowarb_pkt[i].marker;
        emerged[rowarb_pkt[i].marker]       = 1'b1;
        emerged_cnt++;
        rel_q.push_back(rowarb_pkt[i].data_ptr);
      end
    end
    if (bkarb_pkt_valid && !bkarb_pkt_ignore && bkarb_cmd >= CMD_MRS) begin
      released++;
      chk_pending = 1'b1;
      chk_marker  = slot_marker[bkarb_data_ptr];
    end
  endtask

  task automatic report(input string name);
    $display("Test %-10s finished, %0d failures so far", name,
             errors + u_dut.u_assert.error_count);
  endtask

  initial begin
    void'($urandom(32'h38b));
    rst              = 1'b1;
    ui_pkt           = '0;
    ui_pkt_valid     = 1'b0;
    bke_rdy          = 2'b00;
    bkarb_pkt_valid  = 1'b0;
    bkarb_pkt_ignore = 1'b0;
    bkarb_cmd        = CMD_NOP;
    bkarb_data_ptr   = '0;
    {sent, accepted, emerged_cnt, released, errors} = '0;
    {pkt_quota, pkt_pct, rdy_pct, rel_pct} = '0;
    {real_only, took, chk_pending} = '0;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    repeat (2) run_cycle();
    report("reset");

    // Fill every slot with the engines stalled
    pkt_quota = `ROWARB_DEPTH;
    pkt_pct   = 100;
    while (accepted < `ROWARB_DEPTH) run_cycle();
    repeat (4) run_cycle();
    assert (!rowarb_rdy) else begin
      $display("[FAIL] %0t rowarb_rdy got 1 expected 0", $time);
      errors++;
    end
    rdy_pct   = 100;
    rel_pct   = 100;
    real_only = 1'b1;
    while (released < 1) run_cycle();
    run_cycle();
    assert (rowarb_rdy) else begin
      $display("[FAIL] %0t rowarb_rdy got 0 expected 1", $time);
      errors++;
    end
    report("full_free");

    // Mixed traffic with random stalls and command kinds
    pkt_quota = sent + 150;
    pkt_pct   = 60;
    rdy_pct   = 50;
    rel_pct   = 60;
    real_only = 1'b0;
    repeat (TRAFFIC_CYC) run_cycle();
    report("traffic");

    // Drain until every accepted packet has come out and been released
    pkt_quota = sent;
    rdy_pct   = 100;
    rel_pct   = 100;
    real_only = 1'b1;
    while (ui_pkt_valid || released < accepted) run_cycle();
    run_cycle();
    assert (emerged_cnt == accepted) else begin
      $display("[FAIL] %0t emerged_cnt got %0d expected %0d", $time, emerged_cnt, accepted);
      errors++;
    end
    for (int m = 0; m < sent; m++) begin
      assert (emerged[8'(m)]) else begin
        $display("Marker %0d was accepted but never left an engine output", m);
        errors++;
      end
    end
    report("drain");

    fails = errors + u_dut.u_assert.error_count;
    $display("Summary: %0d failures, %0d accepted, %0d emerged, %0d released",
             fails, accepted, emerged_cnt, released);
    if (fails == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- verilog/engine_dispatch.sv
`timescale 1ns/1ns
`include "row_arbiter_macros.svh"

// Routes metadata to the bank-engine queue or the AiM queue
module engine_dispatch import row_arbiter_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            inject_req,        // Scheduler pop
  input  pkt_meta_t       meta_in,           // Registered memory output
  output logic [1:0]      engine_prog_full,
  output pkt_meta_t [1:0] rowarb_pkt,
  output logic [1:0]      rowarb_pkt_valid,
  input  logic [1:0]      bke_rdy
);
  logic       inject;   // Lines up with meta_in
  logic [1:0] eng_wr;
  logic [1:0] eng_empty;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) inject <= 1'b0;
    else     inject <= inject_req;  // Memory read takes one edge
  end

  always_comb begin
    eng_wr = '0;
    eng_wr[prio_class(meta_in.prio)] = inject;
  end

  for (genvar i = 0; i < 2; i++) begin : g_eng_q
    sync_fifo #(
      .WIDTH     ($bits(pkt_meta_t)),
      .DEPTH     (`PKTQ_DEPTH),
      .PROG_FULL (`PKTQ_PROG_FULL)
    ) u_eng_q (
      .clk,
      .rst,
      .wr_en     (eng_wr[i]),
      .rd_en     (bke_rdy[i]),       // Empty read ignored inside
      .din       (meta_in),
      .dout      (rowarb_pkt[i]),
      .empty     (eng_empty[i]),
      .prog_full (engine_prog_full[i])
    );
  end

  assign rowarb_pkt_valid = ~eng_empty;

endmodule

//--- verilog/prio_scheduler.sv
`timescale 1ns/1ns
`include "row_arbiter_macros.svh"

// Slot pointers queued per priority, drained highest priority first
module prio_scheduler import row_arbiter_pkg::*; (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       push,
  input  logic [`PRIO_WIDTH-1:0]     push_prio,
  input  logic [`SLOT_PTR_WIDTH-1:0] push_slot,
  input  logic [1:0]                 engine_prog_full,  // Per engine class
  output logic                       pop,               // Read strobe to metadata memory
  output logic [`SLOT_PTR_WIDTH-1:0] pop_slot
);
  logic [`NUM_PRIO_QUEUES-1:0] q_wr;
  logic [`NUM_PRIO_QUEUES-1:0] q_rd;
  logic [`NUM_PRIO_QUEUES-1:0] q_empty;
  logic [`SLOT_PTR_WIDTH-1:0]  q_dout [`NUM_PRIO_QUEUES];
  logic [`PRIO_WIDTH-1:0]      cur_prio;   // Lowest non-empty queue index
  logic                        cur_class;

  for (genvar i = 0; i < `NUM_PRIO_QUEUES; i++) begin : g_ptr_q
    sync_fifo #(
      .WIDTH     (`SLOT_PTR_WIDTH),
      .DEPTH     (`ROWARB_DEPTH),    // Every slot may sit in one queue
      .PROG_FULL (`ROWARB_DEPTH)
    ) u_ptr_q (
      .clk,
      .rst,
      .wr_en     (q_wr[i]),
      .rd_en     (q_rd[i]),
      .din       (push_slot),
      .dout      (q_dout[i]),
      .empty     (q_empty[i]),
      .prog_full ()
    );
  end

  // Steer push to the queue of its priority
  always_comb begin
    q_wr = '0;
    for (int i = 0; i < `NUM_PRIO_QUEUES; i++) begin
      if (push_prio == `PRIO_WIDTH'(i)) q_wr[i] = push;
    end
  end

  // Priority encoder
  always_comb begin
    cur_prio = '0;
    for (int i = `NUM_PRIO_QUEUES - 1; i >= 0; i--) begin
      if (!q_empty[i]) cur_prio = `PRIO_WIDTH'(i);
    end
  end

  assign cur_class = prio_class(cur_prio);
  // Hold off while the target engine queue is near full
  assign pop      = !(&q_empty) && !engine_prog_full[cur_class];
  assign pop_slot = q_dout[cur_prio];

  always_comb begin
    q_rd = '0;
    q_rd[cur_prio] = pop;
  end

endmodule

//--- verilog/row_arbiter.sv
`timescale 1ns/1ns
`include "row_arbiter_macros.svh"

module row_arbiter import row_arbiter_pkg::*; (
  input  logic                       clk,
  input  logic                       rst,
  // User interface
  input  pkt_t                       ui_pkt,
  input  logic                       ui_pkt_valid,
  output logic                       rowarb_rdy,
  // Engine outputs, 0 is bank engine and 1 is AiM engine
  output pkt_meta_t [1:0]            rowarb_pkt,
  output logic [1:0]                 rowarb_pkt_valid,
  input  logic [1:0]                 bke_rdy,
  // Bank arbiter
  input  logic                       bkarb_pkt_valid,
  input  logic                       bkarb_pkt_ignore,
  input  cmd_t                       bkarb_cmd,
  input  logic [`SLOT_PTR_WIDTH-1:0] bkarb_data_ptr,
  output logic [`DATA_WIDTH-1:0]     rowarb_data,
  output logic [`MASK_WIDTH-1:0]     rowarb_mask
);
  logic                       accept;        // Packet taken this edge
  logic                       full;
  logic [`SLOT_PTR_WIDTH-1:0] free_slot;
  logic                       release_slot;
  logic                       pop;
  logic [`SLOT_PTR_WIDTH-1:0] pop_slot;
  pkt_meta_t                  meta_out;
  logic [1:0]                 engine_prog_full;

  assign rowarb_rdy = !full;
  assign accept     = ui_pkt_valid && rowarb_rdy;

  slot_tracker u_tracker (
    .clk, .rst, .set(accept), .clr(release_slot), .clr_slot(bkarb_data_ptr),
    .free_slot, .full
  );

  slot_memory u_mem (
    .clk, .rst, .wr_en(accept), .wr_slot(free_slot), .wr_pkt(ui_pkt),
    .meta_rd(pop), .meta_slot(pop_slot), .meta_out,
    .bkarb_pkt_valid, .bkarb_pkt_ignore, .bkarb_cmd, .bkarb_data_ptr,
    .release_slot, .rowarb_data, .rowarb_mask
  );

  prio_scheduler u_sched (
    .clk, .rst, .push(accept), .push_prio(ui_pkt.prio), .push_slot(free_slot),
    .engine_prog_full, .pop, .pop_slot
  );

  engine_dispatch u_dispatch (
    .clk, .rst, .inject_req(pop), .meta_in(meta_out),
    .engine_prog_full, .rowarb_pkt, .rowarb_pkt_valid, .bke_rdy
  );

endmodule

//--- verilog/row_arbiter_macros.svh
`ifndef ROW_ARBITER_MACROS_SVH
`define ROW_ARBITER_MACROS_SVH

// Packet store
`define ROWARB_DEPTH    16   // Slots in packet and data memories
`define SLOT_PTR_WIDTH  4    // Slot pointer, log2 of depth

// Payload fields
`define DATA_WIDTH      64
`define MASK_WIDTH      8    // One bit per data byte

// Address fields
`define ROW_ADDR_WIDTH  14
`define BK_ADDR_WIDTH   4
`define COL_ADDR_WIDTH  6

// Priority queues and engine queues
`define PRIO_WIDTH      2
`define NUM_PRIO_QUEUES 3    // Priorities 0..2, 0 is highest
`define PKTQ_DEPTH      8
`define PKTQ_PROG_FULL  6    // Leaves room for two pops in flight

`endif

//--- verilog/row_arbiter_pkg.sv
`include "row_arbiter_macros.svh"

package row_arbiter_pkg;

  // Request type carried by each packet
  typedef enum logic [1:0] {
    REQ_RD,
    REQ_WR,
    REQ_AIM
  } req_t;

  // Bank arbiter commands, CMD_MRS and above consume a slot
  typedef enum logic [2:0] {
    CMD_NOP,
    CMD_ACT,
    CMD_PRE,
    CMD_REF,
    CMD_MRS,
    CMD_WR,
    CMD_RD
  } cmd_t;

  // Inbound packet from the user interface
  typedef struct packed {
    logic [7:0]                    marker;    // Tag for tracking
    logic                          bcast;
    logic [`PRIO_WIDTH-1:0]        prio;
    logic [`BK_ADDR_WIDTH-1:0]     bk_addr;
    logic [`ROW_ADDR_WIDTH-1:0]    row_addr;
    logic [`COL_ADDR_WIDTH-1:0]    col_addr;
    req_t                          req_type;
    logic [`MASK_WIDTH-1:0]        mask;
    logic [`DATA_WIDTH-1:0]        data;
  } pkt_t;

  // Metadata sent to the engines, payload stays behind in the data memory
  typedef struct packed {
    logic [7:0]                    marker;
    logic                          bcast;
    logic [`PRIO_WIDTH-1:0]        prio;
    logic [`BK_ADDR_WIDTH-1:0]     bk_addr;
    logic [`ROW_ADDR_WIDTH-1:0]    row_addr;
    logic [`COL_ADDR_WIDTH-1:0]    col_addr;
    req_t                          req_type;
    logic [`SLOT_PTR_WIDTH-1:0]    data_ptr;  // Slot holding data and mask
  } pkt_meta_t;

  // Engine class of a priority: 1 is the AiM engine, 0 and 2 the bank engine
  function automatic logic prio_class(input logic [`PRIO_WIDTH-1:0] prio);
    return (prio == `PRIO_WIDTH'(1));
  endfunction

endpackage

//--- verilog/slot_memory.sv
`timescale 1ns/1ns
`include "row_arbiter_macros.svh"

// Metadata store and payload store, written together at one slot
module slot_memory import row_arbiter_pkg::*; (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       wr_en,
  input  logic [`SLOT_PTR_WIDTH-1:0] wr_slot,
  input  pkt_t                       wr_pkt,
  input  logic                       meta_rd,          // Scheduler pop
  input  logic [`SLOT_PTR_WIDTH-1:0] meta_slot,
  output pkt_meta_t                  meta_out,
  input  logic                       bkarb_pkt_valid,
  input  logic                       bkarb_pkt_ignore,
  input  cmd_t                       bkarb_cmd,
  input  logic [`SLOT_PTR_WIDTH-1:0] bkarb_data_ptr,
  output logic                       release_slot,     // Strobe to the tracker
  output logic [`DATA_WIDTH-1:0]     rowarb_data,
  output logic [`MASK_WIDTH-1:0]     rowarb_mask
);
  pkt_meta_t                            meta_mem [`ROWARB_DEPTH];
  logic [`MASK_WIDTH+`DATA_WIDTH-1:0]   data_mem [`ROWARB_DEPTH];  // {mask, data}
  pkt_meta_t                            wr_meta;

  // Header fields plus the slot that keeps the payload
  assign wr_meta = '{marker:   wr_pkt.marker,
                     bcast:    wr_pkt.bcast,
                     prio:     wr_pkt.prio,
                     bk_addr:  wr_pkt.bk_addr,
                     row_addr: wr_pkt.row_addr,
                     col_addr: wr_pkt.col_addr,
                     req_type: wr_pkt.req_type,
                     data_ptr: wr_slot};

  // Slot-consuming command that the bank arbiter actually issues
  assign release_slot = bkarb_pkt_valid && !bkarb_pkt_ignore && (bkarb_cmd >= CMD_MRS);

  always_ff @(posedge clk) begin
    if (wr_en) begin
      meta_mem[wr_slot] <= wr_meta;
      data_mem[wr_slot] <= {wr_pkt.mask, wr_pkt.data};
    end
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      meta_out    <= '0;
      rowarb_data <= '0;
      rowarb_mask <= '0;
    end else begin
      if (meta_rd) meta_out <= meta_mem[meta_slot];
      if (release_slot) {rowarb_mask, rowarb_data} <= data_mem[bkarb_data_ptr];  // Held till next
    end
  end

endmodule

//--- verilog/slot_tracker.sv
`timescale 1ns/1ns
`include "row_arbiter_macros.svh"

// Tracks which store slots hold a packet
module slot_tracker (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       set,       // Occupy free_slot
  input  logic                       clr,       // Free clr_slot
  input  logic [`SLOT_PTR_WIDTH-1:0] clr_slot,
  output logic [`SLOT_PTR_WIDTH-1:0] free_slot, // Lowest unoccupied slot
  output logic                       full
);
  localparam int CNT_W = $clog2(`ROWARB_DEPTH + 1);

  logic [`ROWARB_DEPTH-1:0] occ;     // One bit per slot
  logic [`ROWARB_DEPTH-1:0] occ_nxt;
  logic [CNT_W-1:0]         count;   // Occupied slots

  assign full = (count == CNT_W'(`ROWARB_DEPTH));

  // Priority encoder, lowest clear bit wins
  always_comb begin
    free_slot = '0;
    for (int i = `ROWARB_DEPTH - 1; i >= 0; i--) begin
      if (!occ[i]) free_slot = `SLOT_PTR_WIDTH'(i);
    end
  end

  // Set and clear may land on the same edge at different slots
  always_comb begin
    occ_nxt = occ;
    if (clr) occ_nxt[clr_slot]  = 1'b0;
    if (set) occ_nxt[free_slot] = 1'b1;
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      occ   <= '0;
      count <= '0;
    end else begin
      occ <= occ_nxt;
      if (set && !clr)      count <= count + 1'b1;
      else if (clr && !set) count <= count - 1'b1;
    end
  end

endmodule

//--- verilog/sync_fifo.sv
`timescale 1ns/1ns

// Circular buffer, head shown on dout without a read
module sync_fifo #(
  parameter int WIDTH     = 8,
  parameter int DEPTH     = 16,
  parameter int PROG_FULL = DEPTH
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             wr_en,
  input  logic             rd_en,
  input  logic [WIDTH-1:0] din,
  output logic [WIDTH-1:0] dout,
  output logic             empty,
  output logic             prog_full
);
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];   // Storage array
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;         // Occupancy
  logic             full;
  logic             do_wr;
  logic             do_rd;

  assign full      = (count == CNT_W'(DEPTH));
  assign empty     = (count == '0);
  assign prog_full = (count >= CNT_W'(PROG_FULL));
  assign do_wr     = wr_en && !full;   // Write to full is dropped
  assign do_rd     = rd_en && !empty;  // Read from empty is dropped
  assign dout      = mem[rd_ptr];      // First word falls through

  always_ff @(posedge clk) begin
    if (do_wr) mem[wr_ptr] <= din;
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      // Simultaneous read and write keeps the count
      if (do_wr && !do_rd)      count <= count + 1'b1;
      else if (do_rd && !do_wr) count <= count - 1'b1;
    end
  end

endmodule
